//--- rtl/clint_pkg.sv
// CLINT shared definitions: address map, bus widths, simple-bus structs and compare array
package clint_pkg;

    // Number of harts served, valid from 1 to 16
    localparam int hart_count = 4;
    localparam int hart_idx_w = (hart_count > 1) ? $clog2(hart_count) : 1;

    // AXI port widths
    localparam int addr_w = 16;
    localparam int id_w   = 4;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // Address map
    localparam logic [addr_w-1:0] msip_base     = 16'h0000;
    localparam logic [addr_w-1:0] mtimecmp_base = 16'h4000;
    localparam logic [addr_w-1:0] mtime_lo_addr = 16'hBFF8;
    localparam logic [addr_w-1:0] mtime_hi_addr = 16'hBFFC;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_slverr = 2'd2;
    localparam logic [1:0] resp_decerr = 2'd3;

    // Only single 32-bit beats are supported
    localparam logic [2:0] axi_size_word  = 3'd2;
    localparam logic [1:0] axi_burst_rsvd = 2'b11;

    // One-cycle access from the bridge to the register block
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              wr;
        logic              rd;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wstrb;
    } clint_req_t;

    // Answer from the register block, combinational from the request address
    typedef struct packed {
        logic [data_w-1:0] rdata;
        logic              addr_err;
        logic              wr_err;
    } clint_rsp_t;

    typedef logic [hart_count-1:0][63:0] mtimecmp_arr_t;

endpackage

//--- rtl/axi_clint_bridge.sv
// AXI slave front end turning single-beat accesses into one-cycle register bus pulses
`timescale 1ns/1ns

module axi_clint_bridge import clint_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    // Write address channel
    input  logic              awvalid,
    output logic              awready,
    input  logic [addr_w-1:0] awaddr,
    input  logic [id_w-1:0]   awid,
    input  logic [7:0]        awlen,
    input  logic [2:0]        awsize,
    input  logic [1:0]        awburst,
    // Write data channel
    input  logic              wvalid,
    output logic              wready,
    input  logic [data_w-1:0] wdata,
    input  logic [strb_w-1:0] wstrb,
    input  logic              wlast,
    // Write response channel
    output logic              bvalid,
    input  logic              bready,
    output logic [1:0]        bresp,
    output logic [id_w-1:0]   bid,
    // Read address channel
    input  logic              arvalid,
    output logic              arready,
    input  logic [addr_w-1:0] araddr,
    input  logic [id_w-1:0]   arid,
    input  logic [7:0]        arlen,
    input  logic [2:0]        arsize,
    input  logic [1:0]        arburst,
    // Read data channel
    output logic              rvalid,
    input  logic              rready,
    output logic [1:0]        rresp,
    output logic [id_w-1:0]   rid,
    output logic [data_w-1:0] rdata,
    output logic              rlast,
    // Register bus
    output clint_req_t        req,
    input  clint_rsp_t        rsp
);

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_respond
    } state_t;

    state_t            state;
    logic              ar_take;
    logic              aw_take;
    logic [addr_w-1:0] addr_q;
    logic [id_w-1:0]   id_q;
    logic [data_w-1:0] wdata_q;
    logic [strb_w-1:0] wstrb_q;
    logic              is_write_q;
    logic              fmt_err_q;
    logic [1:0]        resp_code;

    // Reads win over a write offered in the same cycle
    assign arready = (state == st_idle);
    assign awready = (state == st_idle) && !arvalid && awvalid && wvalid;
    assign wready  = awready;
    assign ar_take = arvalid && arready;
    assign aw_take = awvalid && awready;
    assign rlast   = rvalid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= st_idle;
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (ar_take || aw_take) begin
                        state <= st_access;
                    end
                end
                st_access: begin
                    state  <= st_respond;
                    bvalid <= is_write_q;
                    rvalid <= !is_write_q;
                end
                st_respond: begin
                    if ((rvalid && rready) || (bvalid && bready)) begin
                        state  <= st_idle;
                        rvalid <= 1'b0;
                        bvalid <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Capture the request; bursts, wrong sizes and misalignment are caught here
    always_ff @(posedge clk) begin
        if (ar_take) begin
            addr_q     <= araddr;
            id_q       <= arid;
            is_write_q <= 1'b0;
            fmt_err_q  <= (arlen != 8'd0) || (arsize != axi_size_word) ||
                          (araddr[1:0] != 2'b00) || (arburst == axi_burst_rsvd);
        end else if (aw_take) begin
            addr_q     <= awaddr;
            id_q       <= awid;
            wdata_q    <= wdata;
            wstrb_q    <= wstrb;
            is_write_q <= 1'b1;
            fmt_err_q  <= (awlen != 8'd0) || (awsize != axi_size_word) ||
                          (awaddr[1:0] != 2'b00) || (awburst == axi_burst_rsvd) || !wlast;
        end
        if (state == st_access) begin
            if (is_write_q) begin
                bresp <= resp_code;
                bid   <= id_q;
            end else begin
                rresp <= resp_code;
                rid   <= id_q;
                rdata <= (fmt_err_q || rsp.addr_err) ? '0 : rsp.rdata;
            end
        end
    end

    always_comb begin
        if (fmt_err_q) begin
            resp_code = resp_slverr;
        end else if (rsp.addr_err) begin
            resp_code = resp_decerr;
        end else if (is_write_q && rsp.wr_err) begin
            resp_code = resp_slverr;
        end else begin
            resp_code = resp_okay;
        end
    end

    // The pulse is held back for a malformed request
    always_comb begin
        req.addr  = addr_q;
        req.wr    = (state == st_access) && is_write_q && !fmt_err_q;
        req.rd    = (state == st_access) && !is_write_q && !fmt_err_q;
        req.wdata = wdata_q;
        req.wstrb = wstrb_q;
    end

    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable({rdata, rresp, rid}));

    a_b_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable({bresp, bid}));

endmodule

//--- rtl/clint_regs.sv
// CLINT register block holding msip and mtimecmp, with address decode and read mux
`timescale 1ns/1ns

module clint_regs import clint_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  clint_req_t            req,
    output clint_rsp_t            rsp,
    input  logic [63:0]           mtime,
    output mtimecmp_arr_t         mtimecmp,
    output logic [hart_count-1:0] hart_swi
);

    logic                  msip_sel;
    logic                  mtimecmp_sel;
    logic                  mtime_sel;
    logic                  high_sel;
    logic                  hart_ok;
    logic [hart_idx_w-1:0] hart_idx;
    logic [63:0]           cmp_word;
    logic                  wr_en;

    // Region and hart decode
    always_comb begin
        msip_sel     = 1'b0;
        mtimecmp_sel = 1'b0;
        mtime_sel    = 1'b0;
        hart_ok      = 1'b0;
        hart_idx     = '0;
        // Bit 2 picks the upper word of mtimecmp and mtime
        high_sel     = req.addr[2];
        if (req.addr[addr_w-1:12] == msip_base[addr_w-1:12] &&
            req.addr[11:2+hart_idx_w] == '0) begin
            hart_idx = req.addr[2 +: hart_idx_w];
            hart_ok  = hart_idx < hart_count;
            msip_sel = hart_ok;
        end else if (req.addr[addr_w-1:12] == mtimecmp_base[addr_w-1:12] &&
                     req.addr[11:3+hart_idx_w] == '0) begin
            hart_idx     = req.addr[3 +: hart_idx_w];
            hart_ok      = hart_idx < hart_count;
            mtimecmp_sel = hart_ok;
        end else if (req.addr == mtime_lo_addr || req.addr == mtime_hi_addr) begin
            hart_ok   = 1'b1;
            mtime_sel = 1'b1;
        end
    end

    assign cmp_word = mtimecmp[hart_idx];

    // Read data and error flags
    always_comb begin
        rsp.rdata    = '0;
        rsp.addr_err = !(msip_sel || mtimecmp_sel || mtime_sel);
        // mtime is read-only on this port
        rsp.wr_err   = mtime_sel;
        if (msip_sel) begin
            rsp.rdata[0] = hart_swi[hart_idx];
        end else if (mtimecmp_sel) begin
            rsp.rdata = high_sel ? cmp_word[63:32] : cmp_word[31:0];
        end else if (mtime_sel) begin
            rsp.rdata = high_sel ? mtime[63:32] : mtime[31:0];
        end
    end

    assign wr_en = req.wr && !rsp.addr_err && !rsp.wr_err;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hart_swi <= '0;
            // All ones keeps every timer interrupt quiet
            mtimecmp <= '1;
        end else if (wr_en) begin
            if (msip_sel && req.wstrb[0]) begin
                hart_swi[hart_idx] <= req.wdata[0];
            end
            if (mtimecmp_sel) begin
                for (int b = 0; b < strb_w; b++) begin
                    if (req.wstrb[b]) begin
                        mtimecmp[hart_idx][(high_sel ? 32 : 0) + 8*b +: 8] <=
                            req.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // The bridge filters misaligned requests before they reach the bus
    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (req.rd || req.wr) |-> (req.addr[1:0] == 2'b00));

endmodule

//--- rtl/clint_timer.sv
// Shared machine timer with per-hart compare driving the timer interrupts
`timescale 1ns/1ns

module clint_timer import clint_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mtime_increment,
    input  mtimecmp_arr_t         mtimecmp,
    output logic [63:0]           mtime,
    output logic [hart_count-1:0] hart_timeri
);

    // Increment is a single-cycle pulse per tick
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (mtime_increment) begin
            mtime <= mtime + 64'd1;
        end
    end

    // Unsigned compare, registered once per hart
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hart_timeri <= '0;
        end else begin
            for (int h = 0; h < hart_count; h++) begin
                hart_timeri[h] <= (mtime >= mtimecmp[h]);
            end
        end
    end

    a_mtime_mono: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (mtime >= $past(mtime)));

endmodule

//--- rtl/clint_top.sv
// CLINT top level joining the AXI bridge, register block and machine timer
`timescale 1ns/1ns

module clint_top import clint_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [addr_w-1:0]     awaddr,
    input  logic [id_w-1:0]       awid,
    input  logic [7:0]            awlen,
    input  logic [2:0]            awsize,
    input  logic [1:0]            awburst,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [data_w-1:0]     wdata,
    input  logic [strb_w-1:0]     wstrb,
    input  logic                  wlast,
    output logic                  bvalid,
    input  logic                  bready,
    output logic [1:0]            bresp,
    output logic [id_w-1:0]       bid,
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [addr_w-1:0]     araddr,
    input  logic [id_w-1:0]       arid,
    input  logic [7:0]            arlen,
    input  logic [2:0]            arsize,
    input  logic [1:0]            arburst,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [1:0]            rresp,
    output logic [id_w-1:0]       rid,
    output logic [data_w-1:0]     rdata,
    output logic                  rlast,
    // Synchronous to clk, high for one cycle per tick
    input  logic                  mtime_increment,
    output logic [hart_count-1:0] hart_swi,
    output logic [hart_count-1:0] hart_timeri
);

    clint_req_t    req;
    clint_rsp_t    rsp;
    logic [63:0]   mtime;
    mtimecmp_arr_t mtimecmp;

    // Port names match the AXI signals one to one
    axi_clint_bridge i_bridge (.*);

    clint_regs i_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .rsp      (rsp),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .hart_swi (hart_swi)
    );

    clint_timer i_timer (
        .clk             (clk),
        .rst_n           (rst_n),
        .mtime_increment (mtime_increment),
        .mtimecmp        (mtimecmp),
        .mtime           (mtime),
        .hart_timeri     (hart_timeri)
    );

endmodule

//--- tb/clint_tb.sv
// CLINT testbench driving random AXI traffic and checking it against a register model
`timescale 1ns/1ns

module clint_tb import clint_pkg::*; ();

    localparam int n_rand  = 24;
    // Every access and every timer tick counts as one operation
    localparam int num_ops = 5 * n_rand + 5 * hart_count + 60;

    logic                  clk;
    logic                  rst_n;
    logic                  awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic                  arvalid, arready, rvalid, rready, rlast, mtime_increment;
    logic [addr_w-1:0]     awaddr, araddr;
    logic [id_w-1:0]       awid, arid, bid, rid;
    logic [7:0]            awlen, arlen;
    logic [2:0]            awsize, arsize;
    logic [1:0]            awburst, arburst, bresp, rresp;
    logic [data_w-1:0]     wdata, rdata;
    logic [strb_w-1:0]     wstrb;
    logic [hart_count-1:0] hart_swi, hart_timeri;

    // Register model
    logic [hart_count-1:0] msip_m;
    logic [63:0]           cmp_m [hart_count];
    logic [63:0]           ticks;
    int                    errors;
    int                    seed;

    clint_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_data(input string name, input logic [data_w-1:0] exp, act);
        if (exp !== act) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, act);
        if (exp !== act) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_id(input string name, input logic [id_w-1:0] exp, act);
        if (exp !== act) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_irq(input string name, input logic [hart_count-1:0] exp, act);
        if (exp !== act) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [addr_w-1:0] hart_addr(input logic [addr_w-1:0] base,
                                                    input int h, input int stride);
        return base + addr_w'(h * stride);
    endfunction

    // Response expected from the address map and the format rules
    function automatic logic [1:0] expect_resp(input logic [addr_w-1:0] addr,
                                               input logic [7:0] len,
                                               input logic [2:0] size, input logic wr);
        int a;
        a = int'(addr);
        if (len != 8'd0 || size != 3'd2 || addr[1:0] != 2'b00) return resp_slverr;
        if (a >= int'(msip_base) && a < int'(msip_base) + 4 * hart_count) return resp_okay;
        if (a >= int'(mtimecmp_base) && a < int'(mtimecmp_base) + 8 * hart_count)
            return resp_okay;
        if (addr == mtime_lo_addr || addr == mtime_hi_addr) return wr ? resp_slverr : resp_okay;
        return resp_decerr;
    endfunction

    function automatic logic [data_w-1:0] model_read(input logic [addr_w-1:0] addr);
        int a;
        int h;
        a = int'(addr);
        if (a < int'(msip_base) + 4 * hart_count) begin
            h = (a - int'(msip_base)) / 4;
            return data_w'(msip_m[h]);
        end
        if (addr == mtime_lo_addr || addr == mtime_hi_addr) begin
            return addr[2] ? ticks[63:32] : ticks[31:0];
        end
        h = (a - int'(mtimecmp_base)) / 8;
        return addr[2] ? cmp_m[h][63:32] : cmp_m[h][31:0];
    endfunction

    task automatic model_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                               input logic [strb_w-1:0] strb);
        int a;
        int h;
        a = int'(addr);
        if (a < int'(msip_base) + 4 * hart_count) begin
            h = (a - int'(msip_base)) / 4;
            if (strb[0]) msip_m[h] = data[0];
        end else begin
            h = (a - int'(mtimecmp_base)) / 8;
            for (int b = 0; b < strb_w; b++) begin
                if (strb[b]) cmp_m[h][(addr[2] ? 32 : 0) + 8 * b +: 8] = data[8 * b +: 8];
            end
        end
    endtask

    task automatic axi_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                             input logic [strb_w-1:0] strb, input logic [7:0] len,
                             input logic [2:0] size, output logic [1:0] resp);
        logic [31:0]     r;
        logic [id_w-1:0] id;
        int              delay;
        r = $random(seed);
        id = r[id_w-1:0];
        delay = int'(r[10:8]);
        awaddr = addr;
        awid = id;
        awlen = len;
        awsize = size;
        awburst = 2'b01;
        wdata = data;
        wstrb = strb;
        wlast = 1'b1;
        awvalid = 1'b1;
        wvalid = 1'b1;
        // Address and data are accepted together
        do begin
            @(negedge clk);
            if (awready !== wready) begin
                $display("Write address and write data ready signals differ");
                errors++;
            end
        end while (!(awready && wready));
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid = 1'b0;
        do @(negedge clk); while (!bvalid);
        resp = bresp;
        check_id("write bid", id, bid);
        // Stall bready, then take the response
        for (int i = 0; i <= delay; i++) begin
            @(posedge clk);
            #2;
            if (i == delay) bready = 1'b1;
            @(negedge clk);
            if (!bvalid) begin
                $display("Write response dropped before bready was seen");
                errors++;
            end
            check_resp("bresp hold", resp, bresp);
            check_id("bid hold", id, bid);
        end
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [addr_w-1:0] addr, input logic [7:0] len,
                            input logic [2:0] size, output logic [data_w-1:0] data,
                            output logic [1:0] resp);
        logic [31:0]     r;
        logic [id_w-1:0] id;
        int              delay;
        r = $random(seed);
        id = r[id_w-1:0];
        delay = int'(r[10:8]);
        araddr = addr;
        arid = id;
        arlen = len;
        arsize = size;
        arburst = 2'b01;
        arvalid = 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        do @(negedge clk); while (!rvalid);
        resp = rresp;
        data = rdata;
        check_id("read rid", id, rid);
        for (int i = 0; i <= delay; i++) begin
            @(posedge clk);
            #2;
            if (i == delay) rready = 1'b1;
            @(negedge clk);
            if (!rvalid || !rlast) begin
                $display("Read data dropped or rlast low before rready was seen");
                errors++;
            end
            check_data("rdata hold", data, rdata);
            check_resp("rresp hold", resp, rresp);
            check_id("rid hold", id, rid);
        end
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic write_check(input string name, input logic [addr_w-1:0] addr,
                               input logic [data_w-1:0] data, input logic [strb_w-1:0] strb,
                               input logic [7:0] len, input logic [2:0] size);
        logic [1:0] exp;
        logic [1:0] resp;
        exp = expect_resp(addr, len, size, 1'b1);
        axi_write(addr, data, strb, len, size, resp);
        check_resp(name, exp, resp);
        if (exp == resp_okay) model_write(addr, data, strb);
    endtask

    task automatic read_check(input string name, input logic [addr_w-1:0] addr,
                              input logic [7:0] len, input logic [2:0] size);
        logic [1:0]        exp;
        logic [1:0]        resp;
        logic [data_w-1:0] data;
        exp = expect_resp(addr, len, size, 1'b0);
        axi_read(addr, len, size, data, resp);
        check_resp(name, exp, resp);
        if (exp == resp_okay) check_data(name, model_read(addr), data);
    endtask

    // Single-cycle increment pulses with random gaps
    task automatic tick(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            mtime_increment = 1'b1;
            @(posedge clk);
            #2;
            mtime_increment = 1'b0;
            ticks = ticks + 64'd1;
            repeat (int'(r[1:0])) begin
                @(posedge clk);
                #2;
            end
        end
    endtask

    function automatic logic [hart_count-1:0] timer_expect();
        logic [hart_count-1:0] exp;
        for (int h = 0; h < hart_count; h++) exp[h] = (ticks >= cmp_m[h]);
        return exp;
    endfunction

    initial begin
        logic [31:0]       r;
        logic [31:0]       r2;
        int                h;
        logic [addr_w-1:0] addr;
        logic [addr_w-1:0] bad [6];
        logic [63:0]       cmp;
        seed = 12;
        errors = 0;
        ticks = '0;
        msip_m = '0;
        for (int i = 0; i < hart_count; i++) cmp_m[i] = '1;
        rst_n = 1'b0;
        {awvalid, wvalid, wlast, bready, arvalid, rready, mtime_increment} = '0;
        {awaddr, araddr, awid, arid, awlen, arlen, awsize, arsize} = '0;
        {awburst, arburst, wdata, wstrb} = '0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        check_irq("reset hart_swi", '0, hart_swi);
        check_irq("reset hart_timeri", '0, hart_timeri);

        // msip writes with random strobes
        for (int i = 0; i < n_rand; i++) begin
            r = $random(seed);
            r2 = $random(seed);
            h = int'(r[7:0]) % hart_count;
            addr = hart_addr(msip_base, h, 4);
            write_check("msip write", addr, r2, r[11:8], 8'd0, 3'd2);
            check_irq("hart_swi", msip_m, hart_swi);
            read_check("msip read", addr, 8'd0, 3'd2);
        end

        // mtimecmp halves with random strobes
        for (int i = 0; i < n_rand; i++) begin
            r = $random(seed);
            r2 = $random(seed);
            h = int'(r[7:0]) % hart_count;
            addr = hart_addr(mtimecmp_base, h, 8) + (r[8] ? 16'd4 : 16'd0);
            write_check("mtimecmp write", addr, r2, r[15:12], 8'd0, 3'd2);
            read_check("mtimecmp read", addr, 8'd0, 3'd2);
        end

        // mtime is read-only and follows the pulse count
        r = $random(seed);
        tick(12 + int'(r[2:0]));
        read_check("mtime lo", mtime_lo_addr, 8'd0, 3'd2);
        read_check("mtime hi", mtime_hi_addr, 8'd0, 3'd2);
        write_check("mtime write", mtime_lo_addr, $random(seed), 4'hF, 8'd0, 3'd2);
        read_check("mtime after write", mtime_lo_addr, 8'd0, 3'd2);

        // Compare values placed around the current mtime
        for (int i = 0; i < hart_count; i++) begin
            r = $random(seed);
            cmp = ticks + 64'(r[2:0] % 3'd5) - 64'd2;
            write_check("cmp lo", hart_addr(mtimecmp_base, i, 8), cmp[31:0], 4'hF, 8'd0, 3'd2);
            write_check("cmp hi", hart_addr(mtimecmp_base, i, 8) + 16'd4, cmp[63:32], 4'hF,
                        8'd0, 3'd2);
        end
        repeat (4) @(posedge clk);
        #2;
        check_irq("hart_timeri", timer_expect(), hart_timeri);
        tick(3);
        repeat (4) @(posedge clk);
        #2;
        check_irq("hart_timeri after ticks", timer_expect(), hart_timeri);

        // Decode and format errors leave the state alone
        bad[0] = hart_addr(msip_base, hart_count, 4);
        bad[1] = hart_addr(mtimecmp_base, hart_count, 8);
        bad[2] = 16'h2000;
        bad[3] = 16'h8000;
        bad[4] = 16'hBFF0;
        bad[5] = 16'hC000;
        for (int i = 0; i < 6; i++) begin
            write_check("unmapped write", bad[i], 32'hFFFF_FFFF, 4'hF, 8'd0, 3'd2);
            read_check("unmapped read", bad[i], 8'd0, 3'd2);
        end
        write_check("burst write", msip_base, 32'h1, 4'hF, 8'd1, 3'd2);
        write_check("size write", mtimecmp_base, 32'h0, 4'hF, 8'd0, 3'd1);
        write_check("misaligned write", msip_base + 16'd1, 32'h1, 4'hF, 8'd0, 3'd2);
        read_check("burst read", msip_base, 8'd3, 3'd2);
        read_check("size read", mtimecmp_base, 8'd0, 3'd0);
        read_check("misaligned read", mtimecmp_base + 16'd2, 8'd0, 3'd2);
        for (int i = 0; i < hart_count; i++) begin
            read_check("msip state", hart_addr(msip_base, i, 4), 8'd0, 3'd2);
            read_check("cmp lo state", hart_addr(mtimecmp_base, i, 8), 8'd0, 3'd2);
            read_check("cmp hi state", hart_addr(mtimecmp_base, i, 8) + 16'd4, 8'd0, 3'd2);
        end
        check_irq("hart_swi state", msip_m, hart_swi);

        // Mixed traffic under response stalls
        for (int i = 0; i < n_rand; i++) begin
            r = $random(seed);
            h = int'(r[7:0]) % hart_count;
            addr = r[9] ? hart_addr(msip_base, h, 4)
                        : hart_addr(mtimecmp_base, h, 8) + (r[10] ? 16'd4 : 16'd0);
            if (r[8]) write_check("mixed write", addr, $random(seed), r[15:12], 8'd0, 3'd2);
            else read_check("mixed read", addr, 8'd0, 3'd2);
        end

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (num_ops * 200) @(posedge clk);
        $display("Run timed out after %0d cycles without finishing", num_ops * 200);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- filelist.f
rtl/clint_pkg.sv
rtl/axi_clint_bridge.sv
rtl/clint_regs.sv
rtl/clint_timer.sv
rtl/clint_top.sv
tb/clint_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = clint_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Result: FAILED
PASS_MSG  = Result: PASSED

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
